// ==== common/seqPkg.sv ====
`default_nettype none

package seqPkg;

    //////////////////////////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////////////////////////

    // alu opcodes, carried in CTRL bits 3:1
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluXor = 3'd4
    } aluOp_t;

    // sequencer states
    typedef enum logic [2:0] {
        stIdle  = 3'd0,
        stSeed0 = 3'd1,
        stSeed1 = 3'd2,
        stStep  = 3'd3,
        stDone  = 3'd4
    } seqState_t;

    //////////////////////////////////////////////////////////////////////
    // bus and flag bundles
    //////////////////////////////////////////////////////////////////////

    // host request side of the apb port
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apbReq_t;

    // response, zero wait states so just read data
    typedef struct packed {
        logic [31:0] prdata;
    } apbRsp_t;

    // carry is the borrow on subtract, 0 for logic ops
    // low is the unsigned compare opA < opB
    typedef struct packed {
        logic carry;
        logic zero;
        logic negative;
        logic low;
    } aluFlags_t;

    //////////////////////////////////////////////////////////////////////
    // address map
    //////////////////////////////////////////////////////////////////////

    localparam logic [7:0] AddrCtrl    = 8'h00;
    localparam logic [7:0] AddrCount   = 8'h04;
    localparam logic [7:0] AddrSeed0   = 8'h08;
    localparam logic [7:0] AddrSeed1   = 8'h0C;
    localparam logic [7:0] AddrStatus  = 8'h10;
    // register i sits at base + 4*i
    localparam logic [7:0] AddrRegBase = 8'h40;

endpackage

`default_nettype wire

// ==== datapath/seqAlu.sv ====
`default_nettype none

module seqAlu #(
    parameter int DataWidth = 16
) (
    input  logic [DataWidth-1:0] opA,
    input  logic [DataWidth-1:0] opB,
    input  seqPkg::aluOp_t       opcode,
    output logic [DataWidth-1:0] result,
    output seqPkg::aluFlags_t    flags
);

    import seqPkg::*;

    // one extra bit on top for carry or borrow
    logic [DataWidth:0] wide;

    always_comb begin
        case (opcode)
            aluAdd: wide = {1'b0, opA} + {1'b0, opB};
            // top bit set when opA < opB, i.e. a borrow
            aluSub: wide = {1'b0, opA} - {1'b0, opB};
            aluAnd: wide = {1'b0, opA & opB};
            aluOr:  wide = {1'b0, opA | opB};
            aluXor: wide = {1'b0, opA ^ opB};
            // unused encodings give zero
            default: wide = '0;
        endcase
    end

    assign result = wide[DataWidth-1:0];

    // logic ops leave the top bit clear so carry reads 0
    assign flags.carry    = wide[DataWidth];
    assign flags.zero     = (result == '0);
    assign flags.negative = result[DataWidth-1];
    assign flags.low      = (opA < opB);

endmodule

`default_nettype wire

// ==== datapath/regFile.sv ====
`default_nettype none

module regFile #(
    parameter  int DataWidth = 16,
    parameter  int NumRegs   = 16,
    localparam int AddrWidth = $clog2(NumRegs)
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [AddrWidth-1:0] rdAddrA,
    input  logic [AddrWidth-1:0] rdAddrB,
    output logic [DataWidth-1:0] rdDataA,
    output logic [DataWidth-1:0] rdDataB,
    input  logic [AddrWidth-1:0] hostRdAddr,
    output logic [DataWidth-1:0] hostRdData,
    input  logic [AddrWidth-1:0] wrAddr,
    input  logic                 wrEn,
    input  logic [DataWidth-1:0] wrData
);

    logic [DataWidth-1:0] regs [NumRegs];

    // async reads, same-cycle write shows up next cycle
    assign rdDataA    = regs[rdAddrA];
    assign rdDataB    = regs[rdAddrB];
    assign hostRdData = regs[hostRdAddr];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            // whole file starts cleared
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

endmodule

`default_nettype wire

// ==== datapath/flagRegister.sv ====
`default_nettype none

module flagRegister (
    input  logic              clk,
    input  logic              rstN,
    input  logic              flagCapture,
    input  logic              clearFlags,
    input  seqPkg::aluFlags_t flagsIn,
    output seqPkg::aluFlags_t lastFlags,
    output logic              stickyCarry
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            lastFlags   <= '0;
            stickyCarry <= 1'b0;
        end else if (clearFlags) begin
            // new run starts clean
            lastFlags   <= '0;
            stickyCarry <= 1'b0;
        end else if (flagCapture) begin
            lastFlags   <= flagsIn;
            // any carry during the run sticks
            stickyCarry <= stickyCarry | flagsIn.carry;
        end
    end

endmodule

`default_nettype wire

// ==== hw/seqCtrl.sv ====
`default_nettype none

module seqCtrl #(
    parameter  int NumRegs    = 16,
    localparam int AddrWidth  = $clog2(NumRegs),
    localparam int CountWidth = $clog2(NumRegs + 1)
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  startPulse,
    input  logic [CountWidth-1:0] termCount,
    output logic [AddrWidth-1:0]  rdAddrA,
    output logic [AddrWidth-1:0]  rdAddrB,
    output logic [AddrWidth-1:0]  wrAddr,
    output logic                  wrEn,
    output logic                  wrSelSeed,
    output logic                  seedSel,
    output logic                  flagCapture,
    output logic                  clearFlags,
    output logic                  busy,
    output logic                  done
);

    import seqPkg::*;

    seqState_t            state;
    seqState_t            stateNext;
    // index of the term being written in stStep
    logic [AddrWidth-1:0] idx;
    logic                 startAccept;
    logic                 lastStep;

    // start only counts when no run is in flight
    assign startAccept = startPulse && (state == stIdle || state == stDone);
    // final term is index termCount-1
    assign lastStep    = (CountWidth'(idx) + 1'b1) == termCount;
    // sticky carry covers one run only
    assign clearFlags  = startAccept;

    assign busy = (state == stSeed0) || (state == stSeed1) || (state == stStep);
    assign done = (state == stDone);

    //////////////////////////////////////////////////////////////////////
    // state and index
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        stateNext = state;
        case (state)
            stIdle, stDone: begin
                if (startAccept) begin
                    stateNext = stSeed0;
                end
            end
            stSeed0: stateNext = stSeed1;
            // count of 2 means seeds only
            stSeed1: stateNext = (termCount > CountWidth'(2)) ? stStep : stDone;
            stStep: begin
                if (lastStep) begin
                    stateNext = stDone;
                end
            end
            default: stateNext = stIdle;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= stIdle;
            idx   <= '0;
        end else begin
            state <= stateNext;
            if (startAccept) begin
                idx <= AddrWidth'(2);
            end else if (state == stStep && !lastStep) begin
                idx <= idx + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // datapath control
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // opA is the previous term, opB the one before
        rdAddrA     = idx - AddrWidth'(1);
        rdAddrB     = idx - AddrWidth'(2);
        wrAddr      = idx;
        wrEn        = 1'b0;
        wrSelSeed   = 1'b0;
        seedSel     = 1'b0;
        flagCapture = 1'b0;
        case (state)
            stSeed0: begin
                wrEn      = 1'b1;
                wrSelSeed = 1'b1;
                wrAddr    = '0;
            end
            stSeed1: begin
                wrEn      = 1'b1;
                wrSelSeed = 1'b1;
                seedSel   = 1'b1;
                wrAddr    = AddrWidth'(1);
            end
            stStep: begin
                wrEn        = 1'b1;
                flagCapture = 1'b1;
            end
            default: ;
        endcase
    end

    // a run writes 0, 1, 2 ... back to back until its last term
    wrContiguous: assert property (@(posedge clk) disable iff (!rstN)
        wrEn && ((CountWidth'(wrAddr) + 1'b1) != termCount)
        |=> wrEn && (wrAddr == $past(wrAddr) + 1'b1));

    // write index never passes the programmed count
    wrAddrInRange: assert property (@(posedge clk) disable iff (!rstN)
        wrEn |-> (CountWidth'(wrAddr) < termCount));

endmodule

`default_nettype wire

// ==== hw/apbCtrlRegs.sv ====
`default_nettype none

module apbCtrlRegs #(
    parameter  int DataWidth  = 16,
    parameter  int NumRegs    = 16,
    localparam int AddrWidth  = $clog2(NumRegs),
    localparam int CountWidth = $clog2(NumRegs + 1)
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  seqPkg::apbReq_t       apbReq,
    output seqPkg::apbRsp_t       apbRsp,
    output logic                  startPulse,
    output seqPkg::aluOp_t        opcode,
    output logic [CountWidth-1:0] termCount,
    output logic [DataWidth-1:0]  seed0,
    output logic [DataWidth-1:0]  seed1,
    output logic [AddrWidth-1:0]  hostRdAddr,
    input  logic [DataWidth-1:0]  hostRdData,
    input  logic                  busy,
    input  logic                  done,
    input  seqPkg::aluFlags_t     lastFlags,
    input  logic                  stickyCarry
);

    import seqPkg::*;

    logic       wrAccess;
    logic       cfgWr;
    logic [7:0] regOffset;
    logic       inWindow;

    // clamp a COUNT write into 2..NumRegs
    function automatic logic [CountWidth-1:0] satCount(input logic [31:0] value);
        if (value < 32'd2) begin
            return CountWidth'(2);
        end
        if (value > NumRegs) begin
            return CountWidth'(NumRegs);
        end
        return value[CountWidth-1:0];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // write side
    //////////////////////////////////////////////////////////////////////

    // transfer lands in the access phase, no wait states
    assign wrAccess = apbReq.psel && apbReq.penable && apbReq.pwrite;
    // config is frozen while a run is in flight
    assign cfgWr    = wrAccess && !busy;

    // start bit is write only, one access cycle wide
    assign startPulse = cfgWr && (apbReq.paddr == AddrCtrl) && apbReq.pwdata[0];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            opcode    <= aluAdd;
            termCount <= CountWidth'(2);
            seed0     <= '0;
            seed1     <= '0;
        end else if (cfgWr) begin
            case (apbReq.paddr)
                AddrCtrl:  opcode    <= aluOp_t'(apbReq.pwdata[3:1]);
                AddrCount: termCount <= satCount(apbReq.pwdata);
                AddrSeed0: seed0     <= apbReq.pwdata[DataWidth-1:0];
                AddrSeed1: seed1     <= apbReq.pwdata[DataWidth-1:0];
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read side
    //////////////////////////////////////////////////////////////////////

    // register window decode, low two address bits ignored
    assign regOffset  = apbReq.paddr - AddrRegBase;
    assign inWindow   = (apbReq.paddr >= AddrRegBase) && (int'(regOffset) < 4 * NumRegs);
    assign hostRdAddr = regOffset[AddrWidth+1:2];

    always_comb begin
        apbRsp.prdata = '0;
        if (inWindow) begin
            apbRsp.prdata = 32'(hostRdData);
        end else begin
            case (apbReq.paddr)
                // start reads back as 0
                AddrCtrl:   apbRsp.prdata = 32'({opcode, 1'b0});
                AddrCount:  apbRsp.prdata = 32'(termCount);
                AddrSeed0:  apbRsp.prdata = 32'(seed0);
                AddrSeed1:  apbRsp.prdata = 32'(seed1);
                // busy, done, flags 5:2, sticky carry
                AddrStatus: apbRsp.prdata = 32'({stickyCarry, lastFlags, done, busy});
                default: ;
            endcase
        end
    end

    // legal apb never has two access phases back to back
    startSingle: assert property (@(posedge clk) disable iff (!rstN)
        startPulse |=> !startPulse);

endmodule

`default_nettype wire

// ==== hw/seqTop.sv ====
`default_nettype none

module seqTop #(
    parameter int DataWidth = 16,
    parameter int NumRegs   = 16
) (
    input  logic            clk,
    input  logic            rstN,
    input  seqPkg::apbReq_t apbReq,
    output seqPkg::apbRsp_t apbRsp,
    output logic            done
);

    import seqPkg::*;

    localparam int AddrWidth  = $clog2(NumRegs);
    localparam int CountWidth = $clog2(NumRegs + 1);

    // host control
    logic                  startPulse;
    aluOp_t                opcode;
    logic [CountWidth-1:0] termCount;
    logic [DataWidth-1:0]  seed0;
    logic [DataWidth-1:0]  seed1;
    logic [AddrWidth-1:0]  hostRdAddr;
    logic [DataWidth-1:0]  hostRdData;

    // sequencer outputs
    logic [AddrWidth-1:0]  rdAddrA;
    logic [AddrWidth-1:0]  rdAddrB;
    logic [AddrWidth-1:0]  wrAddr;
    logic                  wrEn;
    logic                  wrSelSeed;
    logic                  seedSel;
    logic                  flagCapture;
    logic                  clearFlags;
    logic                  busy;

    // datapath
    logic [DataWidth-1:0]  rdDataA;
    logic [DataWidth-1:0]  rdDataB;
    logic [DataWidth-1:0]  aluResult;
    logic [DataWidth-1:0]  wrData;
    aluFlags_t             aluFlags;
    aluFlags_t             lastFlags;
    logic                  stickyCarry;

    // write bus, seeds during the first two cycles then alu
    assign wrData = wrSelSeed ? (seedSel ? seed1 : seed0) : aluResult;

    apbCtrlRegs #(
        .DataWidth (DataWidth),
        .NumRegs   (NumRegs)
    ) apbCtrlRegs_i (
        .clk, .rstN, .apbReq, .apbRsp, .startPulse, .opcode, .termCount,
        .seed0, .seed1, .hostRdAddr, .hostRdData, .busy, .done,
        .lastFlags, .stickyCarry
    );

    seqCtrl #(
        .NumRegs (NumRegs)
    ) seqCtrl_i (
        .clk, .rstN, .startPulse, .termCount, .rdAddrA, .rdAddrB, .wrAddr,
        .wrEn, .wrSelSeed, .seedSel, .flagCapture, .clearFlags, .busy, .done
    );

    regFile #(
        .DataWidth (DataWidth),
        .NumRegs   (NumRegs)
    ) regFile_i (
        .clk, .rstN, .rdAddrA, .rdAddrB, .rdDataA, .rdDataB,
        .hostRdAddr, .hostRdData, .wrAddr, .wrEn, .wrData
    );

    seqAlu #(
        .DataWidth (DataWidth)
    ) seqAlu_i (
        .opA    (rdDataA),
        .opB    (rdDataB),
        .opcode (opcode),
        .result (aluResult),
        .flags  (aluFlags)
    );

    flagRegister flagRegister_i (
        .clk, .rstN, .flagCapture, .clearFlags,
        .flagsIn (aluFlags),
        .lastFlags, .stickyCarry
    );

endmodule

`default_nettype wire

// ==== tests/seqTb.sv ====
`default_nettype none

module seqTb;

    import seqPkg::*;

    localparam int DataWidth = 16;
    localparam int NumRegs   = 16;
    localparam int ClkPeriod = 20;
    localparam int NumRuns   = 9;
    // sequencing per run, then window readback per run, then reset and map checks
    localparam int WatchdogCycles = NumRuns * (NumRegs + 20) + NumRuns * 4 * NumRegs + 200;

    logic     clk;
    logic     rstN;
    apbReq_t  apbReq;
    apbRsp_t  apbRsp;
    logic     done;

    // expected register file and flag state
    logic [DataWidth-1:0] modelRegs [NumRegs];
    aluFlags_t            modelFlags;
    logic                 modelSticky;
    int                   seed = 32'he67050b1;
    aluOp_t               logicOps [4] = '{aluSub, aluAnd, aluOr, aluXor};

    seqTop #(
        .DataWidth (DataWidth),
        .NumRegs   (NumRegs)
    ) dut_i (
        .clk    (clk),
        .rstN   (rstN),
        .apbReq (apbReq),
        .apbRsp (apbRsp),
        .done   (done)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        valueMatch: assert (expected === actual) else begin
            $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    // counts falling edges until done, current edge included
    task automatic waitDone(output int cycles);
        cycles = 0;
        while (!done) begin
            cycles++;
            doneInTime: assert (cycles <= NumRegs + 4) else begin
                $display("done did not rise within %0d cycles of the start", NumRegs + 4);
                $display("ERRORS FOUND");
                $fatal(1, "sequencer timeout");
            end
            @(negedge clk);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // apb host
    //////////////////////////////////////////////////////////////////////

    task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data);
        @(negedge clk);
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = 1'b1;
        apbReq.paddr   = addr;
        apbReq.pwdata  = data;
        // access phase, lands on the next rising edge
        @(negedge clk);
        apbReq.penable = 1'b1;
        @(negedge clk);
        apbReq.psel    = 1'b0;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = 1'b0;
    endtask

    task automatic apbRead(input logic [7:0] addr, output logic [31:0] data);
        @(negedge clk);
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = 1'b0;
        apbReq.paddr   = addr;
        @(negedge clk);
        apbReq.penable = 1'b1;
        // middle of the access phase, away from both edges
        #(ClkPeriod / 4);
        data = apbRsp.prdata;
        @(negedge clk);
        apbReq.psel    = 1'b0;
        apbReq.penable = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // each term is op(term i-1, term i-2)
    task automatic modelRun(input aluOp_t op, input logic [DataWidth-1:0] s0,
                            input logic [DataWidth-1:0] s1, input int count);
        logic [DataWidth:0]   sum;
        logic [DataWidth-1:0] a;
        logic [DataWidth-1:0] b;
        logic [DataWidth-1:0] r;
        logic                 carry;
        modelRegs[0] = s0;
        modelRegs[1] = s1;
        modelFlags   = '0;
        modelSticky  = 1'b0;
        for (int i = 2; i < count; i++) begin
            a     = modelRegs[i-1];
            b     = modelRegs[i-2];
            carry = 1'b0;
            case (op)
                aluAdd: begin
                    sum   = a + b;
                    r     = sum[DataWidth-1:0];
                    carry = sum[DataWidth];
                end
                aluSub: begin
                    r     = a - b;
                    carry = (a < b);
                end
                aluAnd: r = a & b;
                aluOr:  r = a | b;
                default: r = a ^ b;
            endcase
            modelFlags   = {carry, r == '0, r[DataWidth-1], a < b};
            modelSticky  = modelSticky | carry;
            modelRegs[i] = r;
        end
    endtask

    function automatic logic [31:0] expStatus(input logic busyBit, input logic doneBit);
        return 32'({modelSticky, modelFlags, doneBit, busyBit});
    endfunction

    // program and kick off one run, model follows along
    task automatic startRun(input aluOp_t op, input logic [DataWidth-1:0] s0,
                            input logic [DataWidth-1:0] s1, input int count);
        apbWrite(AddrSeed0, 32'(s0));
        apbWrite(AddrSeed1, 32'(s1));
        apbWrite(AddrCount, count);
        apbWrite(AddrCtrl, 32'({op, 1'b1}));
        modelRun(op, s0, s1, count);
    endtask

    task automatic checkWindow(input string name);
        logic [31:0] rd;
        for (int i = 0; i < NumRegs; i++) begin
            apbRead(AddrRegBase + 8'(4 * i), rd);
            checkValue($sformatf("%s reg %0d", name, i), 32'(modelRegs[i]), rd);
        end
        apbRead(AddrStatus, rd);
        checkValue({name, " status"}, expStatus(1'b0, 1'b1), rd);
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0]          rd;
        int                   cycles;
        int                   count;
        logic [DataWidth-1:0] s0;
        logic [DataWidth-1:0] s1;
        int                   countIn [4] = '{0, 1, 9, 40};
        int                   countExp [4] = '{2, 2, 9, NumRegs};
        clk    = 1'b0;
        rstN   = 1'b0;
        apbReq = '0;
        modelRun(aluAdd, '0, '0, 0);
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        // reset values and count saturation
        apbRead(AddrStatus, rd);
        checkValue("reset status", 32'd0, rd);
        apbRead(AddrCount, rd);
        checkValue("reset count", 32'd2, rd);
        for (int i = 0; i < NumRegs; i++) begin
            apbRead(AddrRegBase + 8'(4 * i), rd);
            checkValue($sformatf("reset reg %0d", i), 32'd0, rd);
        end
        for (int i = 0; i < 4; i++) begin
            apbWrite(AddrCount, countIn[i]);
            apbRead(AddrCount, rd);
            checkValue($sformatf("count write %0d", countIn[i]), countExp[i], rd);
        end

        // fibonacci, also times busy against the count
        startRun(aluAdd, 1, 1, NumRegs);
        waitDone(cycles);
        checkValue("fibonacci busy length", NumRegs, cycles);
        checkWindow("fibonacci");

        // remaining opcodes with random seeds and counts
        foreach (logicOps[k]) begin
            s0    = $random(seed);
            s1    = $random(seed);
            count = 2 + ($unsigned($random(seed)) % (NumRegs - 1));
            startRun(logicOps[k], s0, s1, count);
            waitDone(cycles);
            checkValue($sformatf("%s busy length", logicOps[k].name()), count, cycles);
            checkWindow(logicOps[k].name());
        end

        // overflowing add sets the sticky carry
        startRun(aluAdd, 16'hC000, 16'hA000, 6);
        waitDone(cycles);
        checkWindow("overflow");
        apbRead(AddrStatus, rd);
        checkValue("overflow sticky", 32'd1, 32'(rd[6]));
        // a clean run clears it again
        startRun(aluAdd, 1, 2, 8);
        waitDone(cycles);
        checkWindow("no overflow");
        apbRead(AddrStatus, rd);
        checkValue("sticky cleared", 32'd0, 32'(rd[6]));

        // start and seed writes while busy are dropped
        startRun(aluXor, 7, 9, 12);
        apbWrite(AddrSeed0, 32'h1234);
        apbWrite(AddrCtrl, 32'({aluSub, 1'b1}));
        waitDone(cycles);
        checkValue("restart ignored length", 12, cycles + 6);
        checkWindow("restart ignored");
        apbRead(AddrSeed0, rd);
        checkValue("seed held while busy", 32'd7, rd);

        // host reads in the middle of a run
        s0 = $random(seed);
        s1 = $random(seed);
        startRun(aluAdd, s0, s1, NumRegs);
        apbRead(AddrStatus, rd);
        checkValue("status during run", 32'd1, 32'(rd[1:0]));
        apbRead(AddrRegBase, rd);
        apbRead(AddrRegBase + 8'd8, rd);
        waitDone(cycles);
        checkValue("read during run length", NumRegs, cycles + 9);
        checkWindow("read during run");

        $display("NO ERRORS");
        $finish;
    end

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("watchdog expired after %0d cycles, the test did not finish", WatchdogCycles);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog timeout");
    end

endmodule

`default_nettype wire

// ==== tb.f ====
common/seqPkg.sv
datapath/seqAlu.sv
datapath/regFile.sv
datapath/flagRegister.sv
hw/seqCtrl.sv
hw/apbCtrlRegs.sv
hw/seqTop.sv
tests/seqTb.sv

// ==== Bender.yml ====
package:
  name: seq_engine

sources:
  - common/seqPkg.sv
  - datapath/seqAlu.sv
  - datapath/regFile.sv
  - datapath/flagRegister.sv
  - hw/seqCtrl.sv
  - hw/apbCtrlRegs.sv
  - hw/seqTop.sv
  - target: test
    files:
      - tests/seqTb.sv
